// ==== flappyGame.f ====
verilog/flappyPkg.sv
verilog/scoreTimer.sv
verilog/pipeCollision.sv
verilog/livesTracker.sv
verilog/pixelCompositor.sv
verilog/flappyGame.sv
tests/flappyGameTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = flappyGameTb
FILELIST = flappyGame.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJDIR)

// ==== tests/flappyGameTb.sv ====
// testbench for the game core: score timing, lives sequence and pixel colours
`timescale 1ns/1ps

module flappyGameTb;

    logic             Clk;
    logic             Reset;
    flappyPkg::coordT ballX;
    flappyPkg::coordT ballY;
    flappyPkg::coordT pipeX [0:2];
    flappyPkg::coordT pipeY [0:2];
    flappyPkg::coordT drawX;
    flappyPkg::coordT drawY;
    logic             blank;
    flappyPkg::rgbT   Red;
    flappyPkg::rgbT   Green;
    flappyPkg::rgbT   Blue;
    flappyPkg::scoreT Score;

    logic [2:0] heartModel;
    int         edgeCount = 0;
    int         checkErrors = 0;
    bit         timedOut;
    integer     seed;

    flappyGame i_dut
    (
        .Clk    (Clk),
        .Reset  (Reset),
        .BallX  (ballX),
        .BallY  (ballY),
        .Pipe1X (pipeX[0]),
        .Pipe1Y (pipeY[0]),
        .Pipe2X (pipeX[1]),
        .Pipe2Y (pipeY[1]),
        .Pipe3X (pipeX[2]),
        .Pipe3Y (pipeY[2]),
        .DrawX  (drawX),
        .DrawY  (drawY),
        .Blank  (blank),
        .Red    (Red),
        .Green  (Green),
        .Blue   (Blue),
        .Score  (Score)
    );

    initial Clk = 1'b0;
    always #10 Clk = ~Clk;

    // rising edges since reset release
    always @(posedge Clk)
    begin
        if (Reset)
            edgeCount <= 0;
        else
            edgeCount <= edgeCount + 1;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic bit covers(input int x, input int y, input int left, input int top,
                                  input int w, input int h);
        return (x >= left) && (x < left + w) && (y >= top) && (y < top + h);
    endfunction

    // strict inside test of the ball probe against one pipe
    function automatic bit probeInside(input int bx, input int by, input int px, input int py);
        int probeX;
        int probeY;
        probeX = bx + int'(flappyPkg::ProbeOffset);
        probeY = by + int'(flappyPkg::ProbeOffset);
        return (probeX > px) && (probeX < px + int'(flappyPkg::PipeWidth)) &&
               (probeY > py) && (probeY < py + int'(flappyPkg::PipeHeight));
    endfunction

    function automatic logic [23:0] expectedColor(input int x, input int y, input logic vis,
                                                  input int bx, input int by,
                                                  input logic [2:0] hearts);
        logic [23:0] heartColor;
        bit          onPipe;
        int          hs;
        heartColor = flappyPkg::Palette[flappyPkg::HeartIdx];
        hs = int'(flappyPkg::HeartSize);
        onPipe = 1'b0;
        for (int p = 0; p < 3; p++)
            if (covers(x, y, int'(pipeX[p]), int'(pipeY[p]), int'(flappyPkg::PipeWidth),
                       int'(flappyPkg::PipeHeight)))
                onPipe = 1'b1;
        if (!vis)
            return 24'h000000;
        if (covers(x, y, bx, by, int'(flappyPkg::BallSize), int'(flappyPkg::BallSize)))
            return flappyPkg::Palette[flappyPkg::BallIdx];
        if (onPipe)
            return flappyPkg::Palette[flappyPkg::PipeIdx];
        // lost hearts leave a hole of background
        if (covers(x, y, int'(flappyPkg::Heart1X), int'(flappyPkg::HeartY), hs, hs))
            return hearts[0] ? heartColor : flappyPkg::BackgroundColor;
        if (covers(x, y, int'(flappyPkg::Heart2X), int'(flappyPkg::HeartY), hs, hs))
            return hearts[1] ? heartColor : flappyPkg::BackgroundColor;
        if (covers(x, y, int'(flappyPkg::Heart3X), int'(flappyPkg::HeartY), hs, hs))
            return hearts[2] ? heartColor : flappyPkg::BackgroundColor;
        return flappyPkg::BackgroundColor;
    endfunction

    task automatic reportMismatch(input string name, input int got, input int expected);
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, expected);
        checkErrors++;
    endtask

    // compare on the falling edge, half a cycle after the drive edge
    always @(negedge Clk)
    begin : compare
        logic [23:0] expColor;
        int          expScore;
        expColor = expectedColor(int'(drawX), int'(drawY), blank, int'(ballX), int'(ballY),
                                 heartModel);
        expScore = edgeCount / int'(flappyPkg::ScoreTickCycles);
        if (Red !== expColor[23:16])
            reportMismatch("Red", int'(Red), int'(expColor[23:16]));
        if (Green !== expColor[15:8])
            reportMismatch("Green", int'(Green), int'(expColor[15:8]));
        if (Blue !== expColor[7:0])
            reportMismatch("Blue", int'(Blue), int'(expColor[7:0]));
        if (Score !== flappyPkg::scoreT'(expScore))
            reportMismatch("Score", int'(Score), expScore);
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic showHearts(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(posedge Clk);
            blank <= 1'b1;
            drawY <= flappyPkg::coordT'(int'(flappyPkg::HeartY) + 25);
            drawX <= flappyPkg::coordT'(int'(flappyPkg::Heart1X) + 25 + 50 * (i % 3));
        end
    endtask

    task automatic waitForScore(input int target);
        int waited;
        waited = 0;
        while ((int'(Score) < target) && (waited < (target + 1) * 1024))
        begin
            @(posedge Clk);
            waited++;
        end
        if (int'(Score) < target)
        begin
            $display("timeout while waiting for Score to reach %0d", target);
            timedOut = 1'b1;
        end
    endtask

    task automatic randomScenes(input int count, input bit avoidHits);
        int px [0:2];
        int py [0:2];
        int bx;
        int by;
        int dx;
        int dy;
        for (int i = 0; i < count; i++)
        begin
            for (int p = 0; p < 3; p++)
            begin
                px[p] = 380 + randBelow(250);
                py[p] = randBelow(150);
            end
            bx = 350 + randBelow(300);
            by = randBelow(200);
            // drop the ball below the pipes so the FSM stays put
            if (avoidHits && (probeInside(bx, by, px[0], py[0]) ||
                probeInside(bx, by, px[1], py[1]) || probeInside(bx, by, px[2], py[2])))
                by = 400;
            case (randBelow(4))
                0:
                begin
                    dx = bx + randBelow(64);
                    dy = by + randBelow(64);
                end
                1:
                begin
                    dx = px[0] + randBelow(56);
                    dy = py[0] + randBelow(104);
                end
                2:
                begin
                    dx = 440 + randBelow(170);
                    dy = 10 + randBelow(70);
                end
                default:
                begin
                    dx = randBelow(640);
                    dy = randBelow(480);
                end
            endcase
            @(posedge Clk);
            for (int p = 0; p < 3; p++)
            begin
                pipeX[p] <= flappyPkg::coordT'(px[p]);
                pipeY[p] <= flappyPkg::coordT'(py[p]);
            end
            ballX <= flappyPkg::coordT'(bx);
            ballY <= flappyPkg::coordT'(by);
            drawX <= flappyPkg::coordT'(dx);
            drawY <= flappyPkg::coordT'(dy);
            blank <= (randBelow(8) != 0);
        end
    endtask

    // pipes low on screen, ball parked between pipe 1 and pipe 2
    task automatic restoreScene();
        @(posedge Clk);
        for (int p = 0; p < 3; p++)
        begin
            pipeX[p] <= flappyPkg::coordT'(100 + 200 * p);
            pipeY[p] <= 10'd300;
        end
        ballX <= 10'd200;
        ballY <= 10'd320;
    endtask

    // enter a pipe, linger there, then move into the next gap
    task automatic passPipe(input int hitX, input int clearX, input int lostHeart);
        @(posedge Clk);
        ballX <= flappyPkg::coordT'(hitX);
        @(posedge Clk);
        if (lostHeart >= 0)
            heartModel[lostHeart] = 1'b0;
        showHearts(20);
        @(posedge Clk);
        ballX <= flappyPkg::coordT'(clearX);
        showHearts(6);
    endtask

    initial
    begin
        seed = 48;
        timedOut = 1'b0;
        heartModel = 3'b111;
        Reset = 1'b1;
        ballX = 10'd200;
        ballY = 10'd320;
        for (int p = 0; p < 3; p++)
        begin
            pipeX[p] = flappyPkg::coordT'(100 + 200 * p);
            pipeY[p] = 10'd300;
        end
        drawX = 10'd475;
        drawY = 10'd45;
        blank = 1'b1;
        repeat (2) @(posedge Clk);
        Reset <= 1'b0;
        showHearts(6);
        waitForScore(3);
        if (!timedOut)
        begin
            randomScenes(300, 1'b1);
            restoreScene();
            // ball corner past the pipe's left edge so it is not yet in a gap
            passPipe(310, 400, 0);
            passPipe(510, 600, 1);
            passPipe(110, 200, 2);
            // no lives left, so this hit is ignored
            passPipe(310, 400, -1);
            randomScenes(100, 1'b0);
            waitForScore(5);
        end
        $display("error counts: %0d failed checks, %0d timeouts", checkErrors, timedOut);
        if ((checkErrors == 0) && !timedOut)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== verilog/flappyGame.sv ====
// game core top level: score timer, pipe collision, lives FSM and pixel compositor
`timescale 1ns/1ps

module flappyGame
(
    input  logic             Clk,
    input  logic             Reset,
    input  flappyPkg::coordT BallX,
    input  flappyPkg::coordT BallY,
    input  flappyPkg::coordT Pipe1X,
    input  flappyPkg::coordT Pipe1Y,
    input  flappyPkg::coordT Pipe2X,
    input  flappyPkg::coordT Pipe2Y,
    input  flappyPkg::coordT Pipe3X,
    input  flappyPkg::coordT Pipe3Y,
    input  flappyPkg::coordT DrawX,
    input  flappyPkg::coordT DrawY,
    input  logic             Blank,
    output flappyPkg::rgbT   Red,
    output flappyPkg::rgbT   Green,
    output flappyPkg::rgbT   Blue,
    output flappyPkg::scoreT Score
);

    logic       pipeHit;
    logic       pipeCleared;
    logic [2:0] heartIntact;

    scoreTimer i_scoreTimer
    (
        .Clk   (Clk),
        .Reset (Reset),
        .Score (Score)
    );

    pipeCollision i_pipeCollision
    (
        .BallX       (BallX),
        .BallY       (BallY),
        .Pipe1X      (Pipe1X),
        .Pipe1Y      (Pipe1Y),
        .Pipe2X      (Pipe2X),
        .Pipe2Y      (Pipe2Y),
        .Pipe3X      (Pipe3X),
        .Pipe3Y      (Pipe3Y),
        .pipeHit     (pipeHit),
        .pipeCleared (pipeCleared)
    );

    livesTracker i_livesTracker
    (
        .Clk         (Clk),
        .Reset       (Reset),
        .pipeHit     (pipeHit),
        .pipeCleared (pipeCleared),
        .heartIntact (heartIntact)
    );

    // colour path is combinational apart from the heart flags
    pixelCompositor i_pixelCompositor
    (
        .DrawX       (DrawX),
        .DrawY       (DrawY),
        .BallX       (BallX),
        .BallY       (BallY),
        .Pipe1X      (Pipe1X),
        .Pipe1Y      (Pipe1Y),
        .Pipe2X      (Pipe2X),
        .Pipe2Y      (Pipe2Y),
        .Pipe3X      (Pipe3X),
        .Pipe3Y      (Pipe3Y),
        .Blank       (Blank),
        .heartIntact (heartIntact),
        .Red         (Red),
        .Green       (Green),
        .Blue        (Blue)
    );

endmodule

// ==== verilog/pixelCompositor.sv ====
// per-pixel layering of ball, pipes, hearts and background into RGB
`timescale 1ns/1ps

module pixelCompositor
(
    input  flappyPkg::coordT DrawX,
    input  flappyPkg::coordT DrawY,
    input  flappyPkg::coordT BallX,
    input  flappyPkg::coordT BallY,
    input  flappyPkg::coordT Pipe1X,
    input  flappyPkg::coordT Pipe1Y,
    input  flappyPkg::coordT Pipe2X,
    input  flappyPkg::coordT Pipe2Y,
    input  flappyPkg::coordT Pipe3X,
    input  flappyPkg::coordT Pipe3Y,
    input  logic             Blank,
    input  logic [2:0]       heartIntact,
    output flappyPkg::rgbT   Red,
    output flappyPkg::rgbT   Green,
    output flappyPkg::rgbT   Blue
);

    // half-open rectangle test
    function automatic logic inRect
    (
        input flappyPkg::wideCoordT x,
        input flappyPkg::wideCoordT y,
        input flappyPkg::wideCoordT left,
        input flappyPkg::wideCoordT top,
        input flappyPkg::wideCoordT width,
        input flappyPkg::wideCoordT height
    );
        return (x >= left) && (x < left + width) &&
               (y >= top) && (y < top + height);
    endfunction

    flappyPkg::wideCoordT px;
    flappyPkg::wideCoordT py;
    logic                 ballOn;
    logic                 pipeOn;
    logic [2:0]           heartOn;
    logic [23:0]          pixel;

    assign px = flappyPkg::wideCoordT'(DrawX);
    assign py = flappyPkg::wideCoordT'(DrawY);

    // --------------------------------------------------
    // sprite coverage
    // --------------------------------------------------
    assign ballOn = inRect(px, py, flappyPkg::wideCoordT'(BallX),
                           flappyPkg::wideCoordT'(BallY),
                           flappyPkg::BallSize, flappyPkg::BallSize);

    assign pipeOn =
        inRect(px, py, flappyPkg::wideCoordT'(Pipe1X), flappyPkg::wideCoordT'(Pipe1Y),
               flappyPkg::PipeWidth, flappyPkg::PipeHeight) ||
        inRect(px, py, flappyPkg::wideCoordT'(Pipe2X), flappyPkg::wideCoordT'(Pipe2Y),
               flappyPkg::PipeWidth, flappyPkg::PipeHeight) ||
        inRect(px, py, flappyPkg::wideCoordT'(Pipe3X), flappyPkg::wideCoordT'(Pipe3Y),
               flappyPkg::PipeWidth, flappyPkg::PipeHeight);

    assign heartOn[0] = inRect(px, py, flappyPkg::Heart1X, flappyPkg::HeartY,
                               flappyPkg::HeartSize, flappyPkg::HeartSize);
    assign heartOn[1] = inRect(px, py, flappyPkg::Heart2X, flappyPkg::HeartY,
                               flappyPkg::HeartSize, flappyPkg::HeartSize);
    assign heartOn[2] = inRect(px, py, flappyPkg::Heart3X, flappyPkg::HeartY,
                               flappyPkg::HeartSize, flappyPkg::HeartSize);

    // --------------------------------------------------
    // priority select, first match wins
    // --------------------------------------------------
    always_comb
    begin
        if (!Blank)
            pixel = 24'h000000;
        else if (ballOn)
            pixel = flappyPkg::Palette[flappyPkg::BallIdx];
        else if (pipeOn)
            pixel = flappyPkg::Palette[flappyPkg::PipeIdx];
        else if (heartOn[0])
            pixel = heartIntact[0] ? flappyPkg::Palette[flappyPkg::HeartIdx]
                                   : flappyPkg::BackgroundColor;
        else if (heartOn[1])
            pixel = heartIntact[1] ? flappyPkg::Palette[flappyPkg::HeartIdx]
                                   : flappyPkg::BackgroundColor;
        else if (heartOn[2])
            pixel = heartIntact[2] ? flappyPkg::Palette[flappyPkg::HeartIdx]
                                   : flappyPkg::BackgroundColor;
        else
            pixel = flappyPkg::BackgroundColor;
    end

    assign Red   = pixel[23:16];
    assign Green = pixel[15:8];
    assign Blue  = pixel[7:0];

endmodule

// ==== verilog/livesTracker.sv ====
// lives FSM that takes one heart per pipe entry and re-arms once the pipe is cleared
`timescale 1ns/1ps

module livesTracker
(
    input  logic       Clk,
    input  logic       Reset,
    input  logic       pipeHit,
    input  logic       pipeCleared,
    output logic [2:0] heartIntact
);

    flappyPkg::livesStateT state;
    flappyPkg::livesStateT stateNext;

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            state <= flappyPkg::Full3;
        end
        else
        begin
            state <= stateNext;
        end
    end

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb
    begin
        stateNext = state;
        case (state)
            flappyPkg::Full3:     if (pipeHit)     stateNext = flappyPkg::HitFirst;
            flappyPkg::HitFirst:  if (pipeCleared) stateNext = flappyPkg::Left2;
            flappyPkg::Left2:     if (pipeHit)     stateNext = flappyPkg::HitSecond;
            flappyPkg::HitSecond: if (pipeCleared) stateNext = flappyPkg::Left1;
            flappyPkg::Left1:     if (pipeHit)     stateNext = flappyPkg::NoLives;
            flappyPkg::NoLives:   stateNext = flappyPkg::NoLives;
            // unused encodings recover to a full game
            default:              stateNext = flappyPkg::Full3;
        endcase
    end

    // hearts are lost on entry to the hit states
    always_comb
    begin
        heartIntact[0] = (state == flappyPkg::Full3);
        heartIntact[1] = (state == flappyPkg::Full3) ||
                         (state == flappyPkg::HitFirst) ||
                         (state == flappyPkg::Left2);
        heartIntact[2] = (state != flappyPkg::NoLives);
    end

endmodule

// ==== verilog/pipeCollision.sv ====
// ball-versus-pipe geometry: probe-in-pipe hit and between-pipes clear levels
`timescale 1ns/1ps

module pipeCollision
(
    input  flappyPkg::coordT BallX,
    input  flappyPkg::coordT BallY,
    input  flappyPkg::coordT Pipe1X,
    input  flappyPkg::coordT Pipe1Y,
    input  flappyPkg::coordT Pipe2X,
    input  flappyPkg::coordT Pipe2Y,
    input  flappyPkg::coordT Pipe3X,
    input  flappyPkg::coordT Pipe3Y,
    output logic             pipeHit,
    output logic             pipeCleared
);

    // strict bounds on all four sides
    function automatic logic probeInPipe
    (
        input flappyPkg::wideCoordT px,
        input flappyPkg::wideCoordT py,
        input flappyPkg::coordT     pipeX,
        input flappyPkg::coordT     pipeY
    );
        flappyPkg::wideCoordT left;
        flappyPkg::wideCoordT top;
        left = flappyPkg::wideCoordT'(pipeX);
        top  = flappyPkg::wideCoordT'(pipeY);
        return (px > left) && (px < left + flappyPkg::PipeWidth) &&
               (py > top) && (py < top + flappyPkg::PipeHeight);
    endfunction

    flappyPkg::wideCoordT probeX;
    flappyPkg::wideCoordT probeY;
    flappyPkg::wideCoordT ballLeft;

    assign probeX   = flappyPkg::wideCoordT'(BallX) + flappyPkg::ProbeOffset;
    assign probeY   = flappyPkg::wideCoordT'(BallY) + flappyPkg::ProbeOffset;
    assign ballLeft = flappyPkg::wideCoordT'(BallX);

    assign pipeHit = probeInPipe(probeX, probeY, Pipe1X, Pipe1Y) ||
                     probeInPipe(probeX, probeY, Pipe2X, Pipe2Y) ||
                     probeInPipe(probeX, probeY, Pipe3X, Pipe3Y);

    // ball corner sits in a gap past some pipe
    assign pipeCleared =
        ((ballLeft > flappyPkg::wideCoordT'(Pipe1X) + flappyPkg::PipeWidth) &&
         (ballLeft < flappyPkg::wideCoordT'(Pipe2X))) ||
        ((ballLeft > flappyPkg::wideCoordT'(Pipe2X) + flappyPkg::PipeWidth) &&
         (ballLeft < flappyPkg::wideCoordT'(Pipe3X))) ||
        (ballLeft > flappyPkg::wideCoordT'(Pipe3X) + flappyPkg::PipeWidth);

endmodule

// ==== verilog/scoreTimer.sv ====
// free-running play timer that raises the score at a fixed tick rate
`timescale 1ns/1ps

module scoreTimer
(
    input  logic             Clk,
    input  logic             Reset,
    output flappyPkg::scoreT Score
);

    logic [flappyPkg::ScoreCountBits-1:0] tickCount;
    logic                                 tickWrap;

    // last cycle of a score period
    assign tickWrap = (tickCount == flappyPkg::ScoreTickCycles - 1'b1);

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            tickCount <= '0;
            Score     <= '0;
        end
        else if (tickWrap)
        begin
            tickCount <= '0;
            // score wraps at its own width
            Score     <= Score + 1'b1;
        end
        else
        begin
            tickCount <= tickCount + 1'b1;
        end
    end

endmodule

// ==== verilog/flappyPkg.sv ====
// shared screen, sprite, palette, timing and lives-state definitions for the game core
package flappyPkg;

    // --------------------------------------------------
    // coordinate and colour types
    // --------------------------------------------------
    typedef logic [9:0]  coordT;
    // room for a coordinate plus a sprite extent
    typedef logic [10:0] wideCoordT;
    typedef logic [7:0]  rgbT;
    typedef logic [26:0] scoreT;

    // score prescaler
    localparam int ScoreCountBits = 20;
    localparam logic [ScoreCountBits-1:0] ScoreTickCycles = 20'd1024;

    // --------------------------------------------------
    // sprite geometry
    // --------------------------------------------------
    localparam wideCoordT BallSize    = 11'd60;
    // probe sits near the ball centre
    localparam wideCoordT ProbeOffset = 11'd30;
    localparam wideCoordT PipeWidth   = 11'd50;
    localparam wideCoordT PipeHeight  = 11'd100;
    localparam wideCoordT HeartSize   = 11'd50;
    localparam wideCoordT HeartY      = 11'd20;
    localparam wideCoordT Heart1X     = 11'd450;
    localparam wideCoordT Heart2X     = 11'd500;
    localparam wideCoordT Heart3X     = 11'd550;

    // --------------------------------------------------
    // palette
    // --------------------------------------------------
    typedef logic [23:0] PaletteT [0:7];

    localparam PaletteT Palette = '{
        24'h00FF44, 24'hFFDDEE, 24'hCC7711, 24'hDD00FF,
        24'h662255, 24'h662266, 24'h000000, 24'hAAAAAA
    };

    localparam logic [2:0]  BallIdx         = 3'd3;
    localparam logic [2:0]  PipeIdx         = 3'd0;
    localparam logic [2:0]  HeartIdx        = 3'd2;
    localparam logic [23:0] BackgroundColor = 24'h0000FF;

    // hit states wait for the ball to clear the pipe
    typedef enum logic [2:0] {
        Full3,
        HitFirst,
        Left2,
        HitSecond,
        Left1,
        NoLives
    } livesStateT;

endpackage
